/* verilog/zx_pkg.sv */
// Spectrum paging shared definitions
`default_nettype none

package zx_pkg;

	// ====================
	// Bus and field widths
	// ====================

	// CPU side
	typedef logic [15:0] cpu_addr_t;   // Z80 address bus
	typedef logic [7:0]  byte_t;       // Z80 data byte

	// Memory side
	typedef logic [20:0] phys_addr_t;  // 2 MB physical space
	typedef logic [2:0]  bank_t;       // 16K RAM bank 0..7
	typedef logic [3:0]  rom_page_t;   // 16K ROM page 0..15
	typedef logic [14:0] vram_addr_t;  // Two 16K screen banks

	// ULA side
	typedef logic [4:0]  key_row_t;    // Active low key columns
	typedef logic [2:0]  border_t;     // GRB border colour

	// Machine model select
	typedef logic [1:0]  mem_mode_t;

	// ====================
	// Machine models
	// ====================

	localparam mem_mode_t MODE_128   = 2'd0;  // Standard 128K / +2
	localparam mem_mode_t MODE_48    = 2'd1;  // 48K with paging locked
	localparam mem_mode_t MODE_PLUS3 = 2'd2;  // +2A / +3 with 1FFD port
	// Code 3 is spare and runs as 128K

	// ====================
	// Fixed memory layout
	// ====================

	// Banks that never move in normal mode
	localparam bank_t BANK_SLOT1 = 3'd5;  // Slot 4000 and main screen
	localparam bank_t BANK_SLOT2 = 3'd2;  // Slot 8000

	// ROM pages sit in the 101 region of physical space
	localparam logic [2:0] ROM_REGION = 3'b101;

	// 48K BASIC image
	localparam rom_page_t ROM_PAGE_48 = 4'd15;

endpackage

`default_nettype wire

/* verilog/zx_paging_regs.sv */
// Memory paging registers
`timescale 1ns/1ps
`default_nettype none

module zx_paging_regs (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire zx_pkg::mem_mode_t mem_mode,
	input  wire zx_pkg::cpu_addr_t cpu_addr,
	input  wire zx_pkg::byte_t     cpu_dout,
	input  wire                    io_wr,
	output zx_pkg::byte_t          page_reg,
	output zx_pkg::byte_t          page_reg_plus3,
	output logic                   zx48,
	output logic                   plus3
);
	import zx_pkg::*;

	// ====================
	// Model decode
	// ====================

	logic mode_48;
	logic mode_plus3;

	always_comb begin
		case (mem_mode)
			MODE_48: begin
				mode_48    = 1'b1;
				mode_plus3 = 1'b0;
			end
			MODE_PLUS3: begin
				mode_48    = 1'b0;
				mode_plus3 = 1'b1;
			end
			MODE_128: begin
				mode_48    = 1'b0;
				mode_plus3 = 1'b0;
			end
			default: begin // Spare code runs as 128K
				mode_48    = 1'b0;
				mode_plus3 = 1'b0;
			end
		endcase
	end

	// Model follows the input only while reset is held
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			zx48  <= mode_48;
			plus3 <= mode_plus3;
		end
	end

	// ====================
	// Port decode
	// ====================

	logic page_lock;
	logic wr_7ffd;
	logic wr_1ffd;

	// 48K never pages, bit 5 locks until the next reset
	assign page_lock = zx48 | page_reg[5];

	// Partial decode of 7FFD
	// The +3 also needs A14 high to keep clear of 1FFD and the FDC
	assign wr_7ffd = io_wr & ~cpu_addr[15] & ~cpu_addr[1] & ~page_lock
		& (cpu_addr[14] | ~plus3);

	// 1FFD exists only on the +3
	assign wr_1ffd = io_wr & plus3 & (cpu_addr[15:12] == 4'b0001)
		& ~cpu_addr[1] & ~page_lock;

	// ====================
	// Register file
	// ====================

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg       <= '0;
			page_reg_plus3 <= '0;
		end else begin
			if (wr_7ffd) begin
				page_reg <= cpu_dout;        // RAM bank, screen, ROM, lock
			end
			if (wr_1ffd) begin
				page_reg_plus3 <= cpu_dout;  // Special mode and ROM high bit
			end
		end
	end

endmodule

`default_nettype wire

/* verilog/zx_mem_map.sv */
// CPU to physical address mapper
`timescale 1ns/1ps
`default_nettype none

module zx_mem_map (
	input  wire zx_pkg::cpu_addr_t cpu_addr,
	input  wire                    mem_wr,
	input  wire zx_pkg::byte_t     page_reg,
	input  wire zx_pkg::byte_t     page_reg_plus3,
	input  wire                    zx48,
	input  wire                    plus3,
	output zx_pkg::phys_addr_t     ram_addr,
	output logic                   ram_we,
	output zx_pkg::vram_addr_t     vram_addr,
	output logic                   vram_we
);
	import zx_pkg::*;

	// Bank for a slot in the +3 all-RAM layouts
	function automatic bank_t special_bank(input logic [1:0] set_sel, input logic [1:0] slot);
		bank_t bank;
		case (set_sel)
			2'b00: bank = {1'b0, slot};               // 0 1 2 3
			2'b01: bank = {1'b1, slot};               // 4 5 6 7
			2'b10: bank = (slot == 2'd3) ? 3'd3 : {1'b1, slot};  // 4 5 6 3
			default: begin
				case (slot)                           // 4 7 6 3
					2'd0:    bank = 3'd4;
					2'd1:    bank = 3'd7;
					2'd2:    bank = 3'd6;
					default: bank = 3'd3;
				endcase
			end
		endcase
		return bank;
	endfunction

	logic [1:0] slot;
	logic       special;
	logic       rom_sel;
	bank_t      bank;
	rom_page_t  rom_page;

	assign slot    = cpu_addr[15:14];
	assign special = page_reg_plus3[0];
	assign rom_sel = ~special & (slot == 2'd0);  // ROM only in normal mode

	// ====================
	// ROM page select
	// ====================

	always_comb begin
		if (zx48) begin
			rom_page = ROM_PAGE_48;
		end else if (plus3) begin
			rom_page = {2'b10, page_reg_plus3[2], page_reg[4]};  // Pages 8..11
		end else begin
			rom_page = {3'b011, page_reg[4]};  // 128K editor or BASIC
		end
	end

	// ====================
	// RAM bank select
	// ====================

	always_comb begin
		if (special) begin
			bank = special_bank(page_reg_plus3[2:1], slot);
		end else begin
			case (slot)
				2'd1:    bank = BANK_SLOT1;
				2'd2:    bank = BANK_SLOT2;
				2'd3:    bank = page_reg[2:0];  // Switchable top slot
				default: bank = 3'd0;           // ROM slot
			endcase
		end
	end

	always_comb begin
		if (rom_sel) begin
			ram_addr = {ROM_REGION, rom_page, cpu_addr[13:0]};
		end else begin
			ram_addr = {4'b0000, bank, cpu_addr[13:0]};
		end
	end

	// ====================
	// Write enables
	// ====================

	assign ram_we = mem_wr & ~rom_sel;  // ROM is read only

	// Banks 5 and 7 also feed the video copy
	assign vram_we   = ram_we & bank[2] & bank[0];
	assign vram_addr = {bank[1], cpu_addr[13:0]};

endmodule

`default_nettype wire

/* verilog/zx_ula_port.sv */
// ULA port FE
`timescale 1ns/1ps
`default_nettype none

module zx_ula_port (
	input  wire                    clk_sys,
	input  wire                    reset,
	input  wire zx_pkg::cpu_addr_t cpu_addr,
	input  wire zx_pkg::byte_t     cpu_dout,
	input  wire                    io_wr,
	input  wire zx_pkg::key_row_t  key_data,
	input  wire                    tape_in,
	output zx_pkg::border_t        border_color,
	output logic                   ear_out,
	output logic                   mic_out,
	output zx_pkg::byte_t          io_rd_data
);

	// ====================
	// Port write
	// ====================

	logic ula_sel;

	// Every even port reaches the ULA
	assign ula_sel = ~cpu_addr[0];

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= '0;
			ear_out      <= 1'b0;
			mic_out      <= 1'b0;
		end else if (io_wr & ula_sel) begin
			border_color <= cpu_dout[2:0];
			ear_out      <= cpu_dout[4];  // Speaker
			mic_out      <= cpu_dout[3];  // Tape save
		end
	end

	// ====================
	// Port read
	// ====================

	// Bits 7 and 5 float high on real hardware
	always_comb begin
		if (ula_sel) begin
			io_rd_data = {1'b1, ~tape_in, 1'b1, key_data};
		end else begin
			io_rd_data = 8'hFF;  // Nothing answers on odd ports
		end
	end

endmodule

`default_nettype wire

/* verilog/zx_io_top.sv */
// Paging and ULA port top level
`timescale 1ns/1ps
`default_nettype none

module zx_io_top (
	input  wire                     clk_sys,
	input  wire                     reset,
	input  wire zx_pkg::mem_mode_t  mem_mode,

	// CPU bus
	input  wire zx_pkg::cpu_addr_t  cpu_addr,
	input  wire zx_pkg::byte_t      cpu_dout,
	input  wire                     io_wr,     // One cycle strobe
	input  wire                     mem_wr,    // Level for the whole access

	// Keyboard and tape
	input  wire zx_pkg::key_row_t   key_data,
	input  wire                     tape_in,

	// Memory side
	output wire zx_pkg::phys_addr_t ram_addr,
	output wire                     ram_we,
	output wire zx_pkg::vram_addr_t vram_addr,
	output wire                     vram_we,

	// I/O and video side
	output wire zx_pkg::byte_t      io_rd_data,
	output wire zx_pkg::border_t    border_color,
	output wire                     ear_out,
	output wire                     mic_out,
	output wire                     page_scr
);
	import zx_pkg::*;

	// Paging state
	byte_t page_reg;
	byte_t page_reg_plus3;
	logic  zx48;
	logic  plus3;

	// ====================
	// Paging
	// ====================

	zx_paging_regs paging_regs (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.mem_mode       (mem_mode),
		.cpu_addr       (cpu_addr),
		.cpu_dout       (cpu_dout),
		.io_wr          (io_wr),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.zx48           (zx48),
		.plus3          (plus3)
	);

	zx_mem_map mem_map (
		.cpu_addr       (cpu_addr),
		.mem_wr         (mem_wr),
		.page_reg       (page_reg),
		.page_reg_plus3 (page_reg_plus3),
		.zx48           (zx48),
		.plus3          (plus3),
		.ram_addr       (ram_addr),
		.ram_we         (ram_we),
		.vram_addr      (vram_addr),
		.vram_we        (vram_we)
	);

	assign page_scr = page_reg[3];  // Shadow screen in bank 7

	// ====================
	// ULA
	// ====================

	zx_ula_port ula_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.cpu_addr     (cpu_addr),
		.cpu_dout     (cpu_dout),
		.io_wr        (io_wr),
		.key_data     (key_data),
		.tape_in      (tape_in),
		.border_color (border_color),
		.ear_out      (ear_out),
		.mic_out      (mic_out),
		.io_rd_data   (io_rd_data)
	);

endmodule

`default_nettype wire

/* tests/tb_clock_gen.sv */
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	input  wire  reset_req,  // Restart the reset pulse
	output logic clk_sys,
	output wire  reset
);

	logic [1:0] hold_cnt;

	initial begin
		clk_sys  = 1'b0;
		hold_cnt = 2'd3;  // Power-on reset
	end

	always #5 clk_sys = ~clk_sys;  // 10 ns period

	// Reset stays high for three rising edges
	always @(posedge clk_sys) begin
		if (reset_req) begin
			hold_cnt <= 2'd3;
		end else if (hold_cnt != 2'd0) begin
			hold_cnt <= hold_cnt - 2'd1;
		end
	end

	assign reset = (hold_cnt != 2'd0);

endmodule

`default_nettype wire

/* tests/tb_zx_model.svh */
// Paging and ULA reference model
`ifndef TB_ZX_MODEL_SVH
`define TB_ZX_MODEL_SVH

// Expected register state
logic [7:0] m_page_reg;
logic [7:0] m_page_plus3;
logic       m_zx48;
logic       m_plus3;
logic [2:0] m_border;
logic       m_ear;
logic       m_mic;

task automatic model_reset(input logic [1:0] mode);
	m_zx48       = (mode == MODE_48);
	m_plus3      = (mode == MODE_PLUS3);  // Spare code falls through to 128K
	m_page_reg   = 8'h00;
	m_page_plus3 = 8'h00;
	m_border     = 3'd0;
	m_ear        = 1'b0;
	m_mic        = 1'b0;
endtask

// One I/O write strobe as seen at the rising edge
task automatic model_io_write(input logic [15:0] addr, input logic [7:0] data);
	logic locked;
	locked = m_zx48 || m_page_reg[5];
	if (!addr[15] && !addr[1] && !locked && (addr[14] || !m_plus3)) begin
		m_page_reg = data;  // 7FFD
	end
	if (m_plus3 && addr[15:12] == 4'b0001 && !addr[1] && !locked) begin
		m_page_plus3 = data;  // 1FFD
	end
	if (!addr[0]) begin
		m_border = data[2:0];
		m_ear    = data[4];
		m_mic    = data[3];
	end
endtask

function automatic logic [3:0] exp_rom_page();
	if (m_zx48) begin
		return 4'd15;
	end else if (m_plus3) begin
		return 4'd8 + {2'b00, m_page_plus3[2], 1'b0} + {3'b000, m_page_reg[4]};
	end
	return m_page_reg[4] ? 4'd7 : 4'd6;
endfunction

// Four slots packed low to high
function automatic logic [2:0] exp_bank(input logic [1:0] slot);
	logic [11:0] layout;
	if (m_page_plus3[0]) begin
		case (m_page_plus3[2:1])
			2'd0:    layout = {3'd3, 3'd2, 3'd1, 3'd0};
			2'd1:    layout = {3'd7, 3'd6, 3'd5, 3'd4};
			2'd2:    layout = {3'd3, 3'd6, 3'd5, 3'd4};
			default: layout = {3'd3, 3'd6, 3'd7, 3'd4};
		endcase
	end else begin
		layout = {m_page_reg[2:0], 3'd2, 3'd5, 3'd0};
	end
	return layout[slot * 3 +: 3];
endfunction

function automatic logic in_rom_slot(input logic [15:0] addr);
	return !m_page_plus3[0] && (addr[15:14] == 2'd0);
endfunction

function automatic logic [20:0] exp_ram_addr(input logic [15:0] addr);
	if (in_rom_slot(addr)) begin
		return {3'b101, exp_rom_page(), addr[13:0]};
	end
	return {4'b0000, exp_bank(addr[15:14]), addr[13:0]};
endfunction

function automatic logic exp_ram_we(input logic [15:0] addr, input logic wr);
	return wr && !in_rom_slot(addr);
endfunction

function automatic logic exp_vram_we(input logic [15:0] addr, input logic wr);
	logic [2:0] bank;
	bank = exp_bank(addr[15:14]);
	return exp_ram_we(addr, wr) && (bank == 3'd5 || bank == 3'd7);
endfunction

function automatic logic [14:0] exp_vram_addr(input logic [15:0] addr);
	logic [2:0] bank;
	bank = exp_bank(addr[15:14]);
	return {bank[1], addr[13:0]};
endfunction

function automatic logic [7:0] exp_io_rd(input logic [15:0] addr, input logic [4:0] keys,
		input logic tape);
	return addr[0] ? 8'hFF : {1'b1, ~tape, 1'b1, keys};
endfunction

`endif

/* tests/tb_zx_io_top.sv */
// Paging and ULA port testbench
`timescale 1ns/1ps
`default_nettype none

module tb_zx_io_top;
	import zx_pkg::*;

	logic       clk_sys;
	logic       reset;
	logic       reset_req;
	mem_mode_t  mem_mode;
	cpu_addr_t  cpu_addr;
	byte_t      cpu_dout;
	logic       io_wr;
	logic       mem_wr;
	key_row_t   key_data;
	logic       tape_in;
	phys_addr_t ram_addr;
	logic       ram_we;
	vram_addr_t vram_addr;
	logic       vram_we;
	byte_t      io_rd_data;
	border_t    border_color;
	logic       ear_out;
	logic       mic_out;
	logic       page_scr;

	integer seed;
	int     errors;
	string  cur_test;

	`include "tb_zx_model.svh"

	tb_clock_gen clock_gen (.reset_req(reset_req), .clk_sys(clk_sys), .reset(reset));

	zx_io_top uut (
		.clk_sys(clk_sys), .reset(reset), .mem_mode(mem_mode),
		.cpu_addr(cpu_addr), .cpu_dout(cpu_dout), .io_wr(io_wr), .mem_wr(mem_wr),
		.key_data(key_data), .tape_in(tape_in),
		.ram_addr(ram_addr), .ram_we(ram_we), .vram_addr(vram_addr), .vram_we(vram_we),
		.io_rd_data(io_rd_data), .border_color(border_color),
		.ear_out(ear_out), .mic_out(mic_out), .page_scr(page_scr)
	);

	task automatic compare_value(input string what, input logic [31:0] exp,
			input logic [31:0] act);
		assert (act === exp) else begin
			errors++;
			$display("ERR %s %s expected %0h actual %0h", cur_test, what, exp, act);
		end
	endtask

	task automatic check_outputs();
		compare_value("ram_addr", 32'(exp_ram_addr(cpu_addr)), 32'(ram_addr));
		compare_value("ram_we", 32'(exp_ram_we(cpu_addr, mem_wr)), 32'(ram_we));
		compare_value("vram_addr", 32'(exp_vram_addr(cpu_addr)), 32'(vram_addr));
		compare_value("vram_we", 32'(exp_vram_we(cpu_addr, mem_wr)), 32'(vram_we));
		compare_value("io_rd_data", 32'(exp_io_rd(cpu_addr, key_data, tape_in)),
			32'(io_rd_data));
		compare_value("border_color", 32'(m_border), 32'(border_color));
		compare_value("ear_out", 32'(m_ear), 32'(ear_out));
		compare_value("mic_out", 32'(m_mic), 32'(mic_out));
		compare_value("page_scr", 32'(m_page_reg[3]), 32'(page_scr));
	endtask

	task automatic abort_on_timeout(input string what);
		$display("Timeout: %s", what);
		$display("Verification failed");
		$finish;
	endtask

	// Runs from a falling edge to the first falling edge out of reset
	task automatic apply_reset(input mem_mode_t mode);
		int waited;
		mem_mode  = mode;
		io_wr     = 1'b0;
		mem_wr    = 1'b0;
		reset_req = 1'b1;
		@(negedge clk_sys);
		reset_req = 1'b0;
		waited    = 0;
		while (!reset && waited < 8) begin
			@(negedge clk_sys);
			waited++;
		end
		if (!reset) abort_on_timeout("reset never went high");
		waited = 0;
		while (reset && waited < 8) begin
			@(negedge clk_sys);
			waited++;
		end
		if (reset) abort_on_timeout("reset never released");
		model_reset(mode);
	endtask

	// One bus cycle with outputs checked on the next falling edge
	task automatic bus_cycle(input cpu_addr_t addr, input byte_t data, input logic io,
			input logic mem);
		logic [31:0] rnd;
		rnd      = $random(seed);
		cpu_addr = addr;
		cpu_dout = data;
		io_wr    = io;
		mem_wr   = mem;
		key_data = rnd[4:0];
		tape_in  = rnd[5];
		@(negedge clk_sys);
		if (io) begin
			model_io_write(addr, data);  // Taken at the rising edge
		end
		check_outputs();
	endtask

	task automatic run_random(input int cycles);
		logic [31:0] rnd;
		logic [31:0] rnd_addr;
		byte_t       data;
		for (int i = 0; i < cycles; i++) begin
			rnd      = $random(seed);
			rnd_addr = $random(seed);
			data     = rnd[7:0];
			if (rnd[21:16] != 6'd0) begin
				data[5] = 1'b0;  // Lock only now and then
			end
			case (rnd[14:12])
				3'd0:    bus_cycle(16'h7FFD, data, 1'b1, 1'b0);
				3'd1:    bus_cycle(rnd[15] ? 16'h3FFD : 16'h7FFD, data, 1'b1, 1'b0);
				3'd2:    bus_cycle(16'h1FFD, data, 1'b1, 1'b0);
				3'd3:    bus_cycle({rnd_addr[7:0], 8'hFE}, data, 1'b1, 1'b0);
				3'd4:    bus_cycle(rnd_addr[15:0], data, 1'b1, 1'b0);
				3'd7:    bus_cycle(rnd_addr[15:0], data, 1'b0, 1'b0);
				default: bus_cycle(rnd_addr[15:0], data, 1'b0, 1'b1);  // Memory write
			endcase
		end
	endtask

	initial begin
		seed      = 32'h52dc;
		errors    = 0;
		reset_req = 1'b0;
		mem_mode  = MODE_128;
		cpu_addr  = '0;
		cpu_dout  = '0;
		io_wr     = 1'b0;
		mem_wr    = 1'b0;
		key_data  = 5'h1F;
		tape_in   = 1'b0;
		@(negedge clk_sys);

		// ====================
		cur_test = "reset_128";
		apply_reset(MODE_128);
		bus_cycle(16'h0000, 8'hA5, 1'b0, 1'b1);
		compare_value("rom_page_6", 32'({3'b101, 4'd6, 14'd0}), 32'(ram_addr));
		compare_value("rom_write", 32'd0, 32'(ram_we));
		compare_value("page_reg", 32'd0, 32'(uut.page_reg));
		compare_value("page_reg_plus3", 32'd0, 32'(uut.page_reg_plus3));

		cur_test = "paging_128";
		apply_reset(MODE_128);
		bus_cycle(16'h7FFD, 8'h1B, 1'b1, 1'b0);  // Bank 3, shadow screen, ROM 7
		bus_cycle(16'hC123, 8'h00, 1'b0, 1'b1);
		compare_value("c000_bank3", 32'({4'b0000, 3'd3, 14'h0123}), 32'(ram_addr));
		compare_value("page_scr_set", 32'd1, 32'(page_scr));
		bus_cycle(16'h7FFD, 8'h27, 1'b1, 1'b0);  // Bank 7 and lock
		bus_cycle(16'h7FFD, 8'h01, 1'b1, 1'b0);
		bus_cycle(16'hC010, 8'h00, 1'b0, 1'b1);
		compare_value("locked_vram_we", 32'd1, 32'(vram_we));
		compare_value("locked_vram_addr", 32'({1'b1, 14'h0010}), 32'(vram_addr));
		apply_reset(MODE_128);
		run_random(400);

		// ====================
		cur_test = "paging_48";
		apply_reset(MODE_48);
		bus_cycle(16'h7FFD, 8'h07, 1'b1, 1'b0);
		bus_cycle(16'hC000, 8'h00, 1'b0, 1'b0);
		compare_value("c000_bank0", 32'd0, 32'(ram_addr));
		run_random(300);
		bus_cycle(16'h0000, 8'h00, 1'b0, 1'b0);
		compare_value("rom_page_15", 32'({3'b101, 4'd15, 14'd0}), 32'(ram_addr));

		cur_test = "paging_plus3";
		apply_reset(MODE_PLUS3);
		bus_cycle(16'h1FFD, 8'h04, 1'b1, 1'b0);
		bus_cycle(16'h7FFD, 8'h10, 1'b1, 1'b0);
		bus_cycle(16'h0000, 8'h00, 1'b0, 1'b0);
		compare_value("rom_page_11", 32'({3'b101, 4'd11, 14'd0}), 32'(ram_addr));
		bus_cycle(16'h3FFD, 8'h03, 1'b1, 1'b0);  // A14 low so the +3 ignores it
		bus_cycle(16'hC000, 8'h00, 1'b0, 1'b0);
		compare_value("a14_decode", 32'd0, 32'(ram_addr));
		bus_cycle(16'h1FFD, 8'h07, 1'b1, 1'b0);  // Banks 4 7 6 3
		bus_cycle(16'h4000, 8'h00, 1'b0, 1'b1);
		compare_value("special_vram_we", 32'd1, 32'(vram_we));
		compare_value("special_vram_addr", 32'({1'b1, 14'd0}), 32'(vram_addr));
		bus_cycle(16'h0000, 8'h00, 1'b0, 1'b1);
		compare_value("special_slot0", 32'({4'b0000, 3'd4, 14'd0}), 32'(ram_addr));
		compare_value("special_ram_we", 32'd1, 32'(ram_we));
		run_random(400);

		// ====================
		cur_test = "ula_port";
		apply_reset(2'd3);
		bus_cycle(16'h12FE, 8'h1D, 1'b1, 1'b0);
		compare_value("border_5", 32'd5, 32'(border_color));
		bus_cycle(16'h00FF, 8'h00, 1'b0, 1'b0);
		compare_value("odd_port", 32'hFF, 32'(io_rd_data));
		run_random(200);

		io_wr  = 1'b0;
		mem_wr = 1'b0;
		$display("Run complete with %0d errors", errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* all.f */
+incdir+tests
verilog/zx_pkg.sv
verilog/zx_paging_regs.sv
verilog/zx_mem_map.sv
verilog/zx_ula_port.sv
verilog/zx_io_top.sv
tests/tb_clock_gen.sv
tests/tb_zx_io_top.sv

/* Bender.yml */
package:
  name: zx_io

sources:
  - verilog/zx_pkg.sv
  - verilog/zx_paging_regs.sv
  - verilog/zx_mem_map.sv
  - verilog/zx_ula_port.sv
  - verilog/zx_io_top.sv
  - target: simulation
    include_dirs:
      - tests
    files:
      - tests/tb_clock_gen.sv
      - tests/tb_zx_io_top.sv
